// ==== include/rename_macros.svh ====
// register file sizes and the zero register, included by the package and by any file using the sizes
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// architectural register count
`define RENAME_ARF_SIZE 32

// physical register count
`define RENAME_PRF_SIZE 64

// zero register index, also its fixed physical tag
`define RENAME_ZERO_REG 31

`endif

// ==== design/rename_pkg.sv ====
// register index and map types shared by the rename stage blocks and the testbench
`default_nettype none

`include "rename_macros.svh"

package rename_pkg;

	// architectural register index
	typedef logic [$clog2(`RENAME_ARF_SIZE)-1:0] areg_t;

	// physical register tag
	typedef logic [$clog2(`RENAME_PRF_SIZE)-1:0] preg_t;

	// one tag per architectural register, entry i for register i
	typedef preg_t [`RENAME_ARF_SIZE-1:0] arch_map_t;

	// free tag count, one bit wider to hold the full count
	typedef logic [$clog2(`RENAME_PRF_SIZE):0] free_count_t;

endpackage

`default_nettype wire

// ==== design/rename_map_table.sv ====
// speculative map table inside the rename stage top for two-wide lookup, tag choice, halts and restore
`default_nettype none

`include "rename_macros.svh"

module rename_map_table
	import rename_pkg::*;
(
	input  wire logic      clock,
	input  wire logic      reset,
	input  wire logic      mispredict,          // one-cycle restore pulse
	input  wire logic      inst1_enable,
	input  wire areg_t     inst1_srca,
	input  wire areg_t     inst1_srcb,
	input  wire areg_t     inst1_dest,
	input  wire logic      inst1_dest_write,
	input  wire logic      inst2_enable,
	input  wire areg_t     inst2_srca,
	input  wire areg_t     inst2_srcb,
	input  wire areg_t     inst2_dest,
	input  wire logic      inst2_dest_write,
	input  wire logic      alloc_valid1,        // lowest free tag offered
	input  wire preg_t     alloc_preg1,
	input  wire logic      alloc_valid2,        // second-lowest free tag offered
	input  wire preg_t     alloc_preg2,
	input  wire arch_map_t committed_map,       // next state of the retirement map
	output logic           halt1,
	output logic           halt2,
	output logic           take1,
	output logic           take2,
	output preg_t          inst1_srca_preg,
	output preg_t          inst1_srcb_preg,
	output preg_t          inst1_dest_preg,
	output preg_t          inst2_srca_preg,
	output preg_t          inst2_srcb_preg,
	output preg_t          inst2_dest_preg
);

	arch_map_t map_q;            // speculative map
	arch_map_t map_next;
	logic      needs1;           // inst 1 wants a new tag
	logic      needs2;
	logic      rename1;          // inst 1 gets its tag this cycle
	logic      rename2;
	logic      avail2;           // a tag remains for inst 2
	preg_t     new_preg2;        // tag offered to inst 2

	////////////////////////////////////////////////////////////
	// allocation decisions
	////////////////////////////////////////////////////////////

	assign needs1 = inst1_enable & inst1_dest_write &
		(inst1_dest != areg_t'(`RENAME_ZERO_REG));    // zero reg never renames
	assign needs2 = inst2_enable & inst2_dest_write &
		(inst2_dest != areg_t'(`RENAME_ZERO_REG));

	// inst 2 takes the first offer when inst 1 takes nothing
	assign avail2    = rename1 ? alloc_valid2 : alloc_valid1;
	assign new_preg2 = rename1 ? alloc_preg2 : alloc_preg1;

	assign halt1 = mispredict | (needs1 & ~alloc_valid1);
	assign halt2 = halt1 | (needs2 & ~avail2);       // keeps program order

	assign rename1 = needs1 & ~halt1;
	assign rename2 = needs2 & ~halt2;

	assign take1 = rename1 | rename2;                // someone used the first offer
	assign take2 = rename1 & rename2;                // both instructions used an offer

	assign inst1_dest_preg = rename1 ? alloc_preg1 : preg_t'(0);
	assign inst2_dest_preg = rename2 ? new_preg2 : preg_t'(0);

	////////////////////////////////////////////////////////////
	// source lookups
	////////////////////////////////////////////////////////////

	always_comb begin
		inst1_srca_preg = '0;                        // disabled inst reads 0
		inst1_srcb_preg = '0;
		inst2_srca_preg = '0;
		inst2_srcb_preg = '0;
		if (inst1_enable) begin
			inst1_srca_preg = map_q[inst1_srca];
			inst1_srcb_preg = map_q[inst1_srcb];
		end
		if (inst2_enable) begin
			inst2_srca_preg = map_q[inst2_srca];
			inst2_srcb_preg = map_q[inst2_srcb];
			if (rename1 && (inst1_dest == inst2_srca)) begin
				inst2_srca_preg = alloc_preg1;   // bypass inst 1 result
			end
			if (rename1 && (inst1_dest == inst2_srcb)) begin
				inst2_srcb_preg = alloc_preg1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// map update
	////////////////////////////////////////////////////////////

	always_comb begin
		map_next = map_q;
		if (mispredict) begin
			map_next = committed_map;                // roll back to committed state
		end else begin
			if (rename1) begin
				map_next[inst1_dest] = alloc_preg1;
			end
			if (rename2) begin
				map_next[inst2_dest] = new_preg2;    // inst 2 wins on same dest
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `RENAME_ARF_SIZE; i++) begin
				map_q[i] <= preg_t'(i);             // identity map
			end
		end else begin
			map_q <= map_next;
		end
	end

	// restore request never lasts past one cycle
	restore_pulse_a: assert property (@(posedge clock) disable iff (reset)
		mispredict |=> !mispredict);

endmodule

`default_nettype wire

// ==== design/retire_map_table.sv ====
// committed map table: one retirement per cycle, hands the overwritten tag back to the free list
`default_nettype none

`include "rename_macros.svh"

module retire_map_table
	import rename_pkg::*;
(
	input  wire logic  clock,
	input  wire logic  reset,
	input  wire logic  retire_valid,         // one retirement this cycle
	input  wire areg_t retire_areg,
	input  wire preg_t retire_preg,          // tag now committed for retire_areg
	output arch_map_t  committed_map,        // includes this cycle's retirement
	output logic       release_valid,
	output preg_t      release_preg          // old committed tag, now dead
);

	arch_map_t committed_q;
	arch_map_t committed_next;

	////////////////////////////////////////////////////////////
	// retirement
	////////////////////////////////////////////////////////////

	always_comb begin
		committed_next = committed_q;
		if (retire_valid) begin
			committed_next[retire_areg] = retire_preg;
		end
	end

	assign committed_map = committed_next;        // next state, seen by restore

	// the previous mapping is no longer reachable once retired over
	assign release_valid = retire_valid;
	assign release_preg  = committed_q[retire_areg];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `RENAME_ARF_SIZE; i++) begin
				committed_q[i] <= preg_t'(i);       // identity map
			end
		end else begin
			committed_q <= committed_next;
		end
	end

	// zero register has no producer, so nothing retires into it
	retire_zero_a: assert property (@(posedge clock) disable iff (reset)
		retire_valid |-> (retire_areg != areg_t'(`RENAME_ZERO_REG)));

endmodule

`default_nettype wire

// ==== design/prf_free_list.sv ====
// physical register free list: offers the two lowest free tags, takes releases, rebuilds on mispredict
`default_nettype none

`include "rename_macros.svh"

module prf_free_list
	import rename_pkg::*;
(
	input  wire logic      clock,
	input  wire logic      reset,
	input  wire logic      mispredict,       // rebuild from committed map
	input  wire logic      take1,            // first offer consumed
	input  wire logic      take2,            // second offer consumed
	input  wire logic      release_valid,
	input  wire preg_t     release_preg,
	input  wire arch_map_t committed_map,
	output logic           alloc_valid1,
	output preg_t          alloc_preg1,      // lowest free tag
	output logic           alloc_valid2,
	output preg_t          alloc_preg2,      // second-lowest free tag
	output free_count_t    free_count
);

	logic [`RENAME_PRF_SIZE-1:0] free_q;      // one bit per tag, set when free
	logic [`RENAME_PRF_SIZE-1:0] free_next;
	logic [`RENAME_PRF_SIZE-1:0] occupied;    // tags held by the committed map
	free_count_t                 count_q;
	free_count_t                 count_now;   // popcount of free_q

	////////////////////////////////////////////////////////////
	// offer selection
	////////////////////////////////////////////////////////////

	always_comb begin
		alloc_valid1 = 1'b0;
		alloc_preg1  = '0;
		alloc_valid2 = 1'b0;
		alloc_preg2  = '0;
		for (int i = 0; i < `RENAME_PRF_SIZE; i++) begin
			if (free_q[i]) begin
				if (!alloc_valid1) begin
					alloc_valid1 = 1'b1;             // first set bit
					alloc_preg1  = preg_t'(i);
				end else if (!alloc_valid2) begin
					alloc_valid2 = 1'b1;             // second set bit
					alloc_preg2  = preg_t'(i);
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// vector update
	////////////////////////////////////////////////////////////

	always_comb begin
		occupied = '0;
		for (int a = 0; a < `RENAME_ARF_SIZE; a++) begin
			occupied[committed_map[a]] = 1'b1;
		end
	end

	always_comb begin
		free_next = free_q;
		if (mispredict) begin
			free_next = ~occupied;                   // exact rebuild, drops in-flight tags
		end else begin
			if (take1) begin
				free_next[alloc_preg1] = 1'b0;
			end
			if (take2) begin
				free_next[alloc_preg2] = 1'b0;
			end
			if (release_valid) begin
				free_next[release_preg] = 1'b1;
			end
		end
	end

	always_comb begin
		count_now = '0;
		for (int i = 0; i < `RENAME_PRF_SIZE; i++) begin
			count_now = count_now + free_count_t'(free_q[i]);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `RENAME_PRF_SIZE; i++) begin
				free_q[i] <= (i >= `RENAME_ARF_SIZE);   // upper half starts free
			end
			count_q <= free_count_t'(`RENAME_PRF_SIZE - `RENAME_ARF_SIZE);
		end else begin
			free_q  <= free_next;
			count_q <= count_now;                    // trails the vector by a cycle
		end
	end

	assign free_count = count_q;

	// double release means two owners of one tag
	release_busy_a: assert property (@(posedge clock) disable iff (reset)
		release_valid |-> !free_q[release_preg]);

	// map table takes only what was offered
	take_offered_a: assert property (@(posedge clock) disable iff (reset)
		take1 |-> alloc_valid1);

endmodule

`default_nettype wire

// ==== design/rename_stage.sv ====
// rename stage top: speculative map, committed map and free list joined for two-wide renaming
`default_nettype none

module rename_stage
	import rename_pkg::*;
(
	input  wire logic  clock,
	input  wire logic  reset,
	input  wire logic  mispredict,
	input  wire logic  inst1_enable,
	input  wire areg_t inst1_srca,
	input  wire areg_t inst1_srcb,
	input  wire areg_t inst1_dest,
	input  wire logic  inst1_dest_write,
	input  wire logic  inst2_enable,
	input  wire areg_t inst2_srca,
	input  wire areg_t inst2_srcb,
	input  wire areg_t inst2_dest,
	input  wire logic  inst2_dest_write,
	input  wire logic  retire_valid,
	input  wire areg_t retire_areg,
	input  wire preg_t retire_preg,
	output preg_t      inst1_srca_preg,
	output preg_t      inst1_srcb_preg,
	output preg_t      inst1_dest_preg,
	output preg_t      inst2_srca_preg,
	output preg_t      inst2_srcb_preg,
	output preg_t      inst2_dest_preg,
	output logic       halt1,
	output logic       halt2,
	output free_count_t free_count
);

	////////////////////////////////////////////////////////////
	// inter-block wires
	////////////////////////////////////////////////////////////

	logic      alloc_valid1;    // free list offers
	preg_t     alloc_preg1;
	logic      alloc_valid2;
	preg_t     alloc_preg2;
	logic      take1;           // map table answers
	logic      take2;
	arch_map_t committed_map;   // restore source for both
	logic      release_valid;
	preg_t     release_preg;

	rename_map_table map_i (
		.clock, .reset, .mispredict,
		.inst1_enable, .inst1_srca, .inst1_srcb, .inst1_dest, .inst1_dest_write,
		.inst2_enable, .inst2_srca, .inst2_srcb, .inst2_dest, .inst2_dest_write,
		.alloc_valid1, .alloc_preg1, .alloc_valid2, .alloc_preg2,
		.committed_map,
		.halt1, .halt2, .take1, .take2,
		.inst1_srca_preg, .inst1_srcb_preg, .inst1_dest_preg,
		.inst2_srca_preg, .inst2_srcb_preg, .inst2_dest_preg
	);

	retire_map_table retire_i (
		.clock, .reset,
		.retire_valid, .retire_areg, .retire_preg,
		.committed_map, .release_valid, .release_preg
	);

	prf_free_list free_i (
		.clock, .reset, .mispredict,
		.take1, .take2, .release_valid, .release_preg, .committed_map,
		.alloc_valid1, .alloc_preg1, .alloc_valid2, .alloc_preg2,
		.free_count
	);

endmodule

`default_nettype wire

// ==== sim/rename_stage_tb.sv ====
// self-checking testbench for the rename stage that runs as top module rename_stage_tb from tb.f
`default_nettype none

`include "rename_macros.svh"

module rename_stage_tb
	import rename_pkg::*;
();

	logic        clock;
	logic        reset;
	logic        mispredict;
	logic        inst1_enable;
	areg_t       inst1_srca;
	areg_t       inst1_srcb;
	areg_t       inst1_dest;
	logic        inst1_dest_write;
	logic        inst2_enable;
	areg_t       inst2_srca;
	areg_t       inst2_srcb;
	areg_t       inst2_dest;
	logic        inst2_dest_write;
	logic        retire_valid;
	areg_t       retire_areg;
	preg_t       retire_preg;
	preg_t       inst1_srca_preg;
	preg_t       inst1_srcb_preg;
	preg_t       inst1_dest_preg;
	preg_t       inst2_srca_preg;
	preg_t       inst2_srcb_preg;
	preg_t       inst2_dest_preg;
	logic        halt1;
	logic        halt2;
	free_count_t free_count;

	preg_t                       spec_ref [`RENAME_ARF_SIZE];   // model speculative map
	preg_t                       comm_ref [`RENAME_ARF_SIZE];   // model committed map
	logic [`RENAME_PRF_SIZE-1:0] free_ref;                      // model free vector
	int                          count_ref;                     // registered count
	areg_t                       inflight_areg [$];             // renamed, in program order
	preg_t                       inflight_preg [$];

	preg_t  exp_srca1;
	preg_t  exp_srcb1;
	preg_t  exp_dest1;
	preg_t  exp_srca2;
	preg_t  exp_srcb2;
	preg_t  exp_dest2;
	logic   exp_halt1;
	logic   exp_halt2;
	logic   exp_ren1;
	logic   exp_ren2;
	int     lowest1;                                            // -1 when no tag
	int     lowest2;
	int     exp_new2;
	int     errors;
	int     cycles;
	logic   timed_out;
	integer seed;

	rename_stage dut_i (.*);

	always #4 clock = ~clock;

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	function automatic int count_ones(input logic [`RENAME_PRF_SIZE-1:0] v);
		int n;
		n = 0;
		for (int t = 0; t < `RENAME_PRF_SIZE; t++)
			if (v[t])
				n++;
		return n;
	endfunction

	function automatic int count_distinct();
		logic [`RENAME_PRF_SIZE-1:0] used;
		used = '0;
		for (int a = 0; a < `RENAME_ARF_SIZE; a++)
			used[comm_ref[a]] = 1'b1;
		return count_ones(used);
	endfunction

	function automatic void reset_model();
		for (int a = 0; a < `RENAME_ARF_SIZE; a++) begin
			spec_ref[a] = preg_t'(a);                          // identity after reset
			comm_ref[a] = preg_t'(a);
		end
		for (int t = 0; t < `RENAME_PRF_SIZE; t++)
			free_ref[t] = (t >= `RENAME_ARF_SIZE);
		count_ref = `RENAME_PRF_SIZE - `RENAME_ARF_SIZE;
		inflight_areg.delete();
		inflight_preg.delete();
		exp_halt1 = 1'b0;
		exp_halt2 = 1'b0;
	endfunction

	// expected outputs of this cycle from the model state and the driven inputs
	function automatic void compute_expected();
		logic need1;
		logic need2;
		lowest1 = -1;
		lowest2 = -1;
		for (int t = 0; t < `RENAME_PRF_SIZE; t++) begin
			if (free_ref[t] && lowest1 < 0)
				lowest1 = t;
			else if (free_ref[t] && lowest2 < 0)
				lowest2 = t;
		end
		need1 = inst1_enable && inst1_dest_write && (inst1_dest != areg_t'(`RENAME_ZERO_REG));
		need2 = inst2_enable && inst2_dest_write && (inst2_dest != areg_t'(`RENAME_ZERO_REG));
		exp_halt1 = mispredict || (need1 && lowest1 < 0);
		exp_ren1  = need1 && !exp_halt1;
		exp_new2  = exp_ren1 ? lowest2 : lowest1;             // inst 2 shifts down if inst 1 idle
		exp_halt2 = exp_halt1 || (need2 && exp_new2 < 0);
		exp_ren2  = need2 && !exp_halt2;
		exp_dest1 = exp_ren1 ? preg_t'(lowest1) : preg_t'(0);
		exp_dest2 = exp_ren2 ? preg_t'(exp_new2) : preg_t'(0);
		exp_srca1 = inst1_enable ? spec_ref[inst1_srca] : preg_t'(0);
		exp_srcb1 = inst1_enable ? spec_ref[inst1_srcb] : preg_t'(0);
		exp_srca2 = preg_t'(0);
		exp_srcb2 = preg_t'(0);
		if (inst2_enable) begin
			exp_srca2 = (exp_ren1 && inst1_dest == inst2_srca) ? exp_dest1 : spec_ref[inst2_srca];
			exp_srcb2 = (exp_ren1 && inst1_dest == inst2_srcb) ? exp_dest1 : spec_ref[inst2_srcb];
		end
	endfunction

	function automatic void advance_model();
		preg_t                       released;
		logic [`RENAME_PRF_SIZE-1:0] occupied;
		released  = preg_t'(0);
		count_ref = count_ones(free_ref);                      // count lags the vector
		if (retire_valid) begin
			released = comm_ref[retire_areg];
			comm_ref[retire_areg] = retire_preg;
			void'(inflight_areg.pop_front());
			void'(inflight_preg.pop_front());
		end
		if (mispredict) begin
			occupied = '0;
			for (int a = 0; a < `RENAME_ARF_SIZE; a++) begin
				spec_ref[a] = comm_ref[a];
				occupied[comm_ref[a]] = 1'b1;
			end
			free_ref = ~occupied;
			inflight_areg.delete();                            // younger work squashed
			inflight_preg.delete();
		end else begin
			if (exp_ren1) begin
				spec_ref[inst1_dest] = exp_dest1;
				free_ref[exp_dest1] = 1'b0;
				inflight_areg.push_back(inst1_dest);
				inflight_preg.push_back(exp_dest1);
			end
			if (exp_ren2) begin
				spec_ref[inst2_dest] = exp_dest2;                  // later write wins
				free_ref[exp_dest2] = 1'b0;
				inflight_areg.push_back(inst2_dest);
				inflight_preg.push_back(exp_dest2);
			end
			if (retire_valid)
				free_ref[released] = 1'b1;
		end
	endfunction

	function automatic void report_mismatch(input string what, input int got, input int want);
		errors++;
		$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, want);
	endfunction

	// outputs compared one time unit before each rising edge
	always @(negedge clock) begin
		#3;
		if (!reset) begin
			compute_expected();
			cycles++;
			if (inst1_srca_preg !== exp_srca1)
				report_mismatch("inst1_srca_preg", int'(inst1_srca_preg), int'(exp_srca1));
			if (inst1_srcb_preg !== exp_srcb1)
				report_mismatch("inst1_srcb_preg", int'(inst1_srcb_preg), int'(exp_srcb1));
			if (inst1_dest_preg !== exp_dest1)
				report_mismatch("inst1_dest_preg", int'(inst1_dest_preg), int'(exp_dest1));
			if (inst2_srca_preg !== exp_srca2)
				report_mismatch("inst2_srca_preg", int'(inst2_srca_preg), int'(exp_srca2));
			if (inst2_srcb_preg !== exp_srcb2)
				report_mismatch("inst2_srcb_preg", int'(inst2_srcb_preg), int'(exp_srcb2));
			if (inst2_dest_preg !== exp_dest2)
				report_mismatch("inst2_dest_preg", int'(inst2_dest_preg), int'(exp_dest2));
			if (halt1 !== exp_halt1)
				report_mismatch("halt1", int'(halt1), int'(exp_halt1));
			if (halt2 !== exp_halt2)
				report_mismatch("halt2", int'(halt2), int'(exp_halt2));
			if (free_count !== free_count_t'(count_ref))
				report_mismatch("free_count", int'(free_count), count_ref);
		end
	end

	// model state steps with the DUT registers
	always @(posedge clock) begin
		if (reset) begin
			reset_model();
		end else begin
			advance_model();
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	task automatic drive_idle();
		inst1_enable = 1'b0;
		inst1_srca = '0;
		inst1_srcb = '0;
		inst1_dest = '0;
		inst1_dest_write = 1'b0;
		inst2_enable = 1'b0;
		inst2_srca = '0;
		inst2_srcb = '0;
		inst2_dest = '0;
		inst2_dest_write = 1'b0;
		retire_valid = 1'b0;
		retire_areg = '0;
		retire_preg = '0;
		mispredict = 1'b0;
	endtask

	task automatic drive_inst1(input areg_t a, input areg_t b, input areg_t d, input logic w);
		inst1_enable = 1'b1;
		inst1_srca = a;
		inst1_srcb = b;
		inst1_dest = d;
		inst1_dest_write = w;
	endtask

	task automatic drive_inst2(input areg_t a, input areg_t b, input areg_t d, input logic w);
		inst2_enable = 1'b1;
		inst2_srca = a;
		inst2_srcb = b;
		inst2_dest = d;
		inst2_dest_write = w;
	endtask

	task automatic random_inst2(input logic must_write);
		inst2_enable = must_write || (($random(seed) & 3) != 0);
		inst2_srca = areg_t'($random(seed));
		inst2_srcb = areg_t'($random(seed));
		inst2_dest = areg_t'($random(seed));
		inst2_dest_write = must_write || (($random(seed) & 1) != 0);
		if (must_write && inst2_dest == areg_t'(`RENAME_ZERO_REG))
			inst2_dest = areg_t'(1);                           // keep every write allocating
	endtask

	task automatic move_inst2_up();
		inst1_enable = inst2_enable;
		inst1_srca = inst2_srca;
		inst1_srcb = inst2_srcb;
		inst1_dest = inst2_dest;
		inst1_dest_write = inst2_dest_write;
	endtask

	// a halted pair stays on the inputs and a lone halted inst 2 moves up to slot 1
	task automatic issue_pair(input logic must_write);
		if (mispredict || !exp_halt2) begin
			random_inst2(must_write);
			move_inst2_up();
			random_inst2(must_write);
		end else if (!exp_halt1) begin
			move_inst2_up();
			random_inst2(must_write);
		end
	endtask

	task automatic check_reset_lookups();
		for (int i = 0; i < `RENAME_ARF_SIZE; i++) begin
			@(negedge clock);
			drive_idle();
			drive_inst1(areg_t'(i), areg_t'(`RENAME_ARF_SIZE - 1 - i), areg_t'(0), 1'b0);
			drive_inst2(areg_t'(i), areg_t'(i), areg_t'(0), 1'b0);
			#2;
			if (inst1_srca_preg !== preg_t'(i))
				report_mismatch("reset lookup inst1_srca_preg", int'(inst1_srca_preg), i);
			if (inst1_srcb_preg !== preg_t'(`RENAME_ARF_SIZE - 1 - i))
				report_mismatch("reset lookup inst1_srcb_preg", int'(inst1_srcb_preg),
					`RENAME_ARF_SIZE - 1 - i);
			if (inst2_srcb_preg !== preg_t'(i))
				report_mismatch("reset lookup inst2_srcb_preg", int'(inst2_srcb_preg), i);
			if (halt1 || halt2)
				report_mismatch("halts after reset", int'({halt1, halt2}), 0);
			if (int'(free_count) != `RENAME_PRF_SIZE - `RENAME_ARF_SIZE)
				report_mismatch("free_count after reset", int'(free_count), 32);
		end
	endtask

	task automatic check_pair_rename();
		@(negedge clock);
		drive_idle();
		drive_inst1(areg_t'(1), areg_t'(2), areg_t'(3), 1'b1);
		drive_inst2(areg_t'(3), areg_t'(`RENAME_ZERO_REG), areg_t'(3), 1'b1);
		#2;
		if (inst1_dest_preg !== preg_t'(`RENAME_ARF_SIZE))
			report_mismatch("pair inst1_dest_preg", int'(inst1_dest_preg), 32);
		if (inst2_dest_preg !== preg_t'(`RENAME_ARF_SIZE + 1))
			report_mismatch("pair inst2_dest_preg", int'(inst2_dest_preg), 33);
		if (inst2_srca_preg !== preg_t'(`RENAME_ARF_SIZE))
			report_mismatch("bypass inst2_srca_preg", int'(inst2_srca_preg), 32);
		if (inst2_srcb_preg !== preg_t'(`RENAME_ZERO_REG))
			report_mismatch("zero reg inst2_srcb_preg", int'(inst2_srcb_preg), 31);
		@(negedge clock);
		drive_idle();
		drive_inst1(areg_t'(3), areg_t'(`RENAME_ZERO_REG), areg_t'(`RENAME_ZERO_REG), 1'b1);
		#2;
		if (inst1_srca_preg !== preg_t'(`RENAME_ARF_SIZE + 1))
			report_mismatch("same dest lookup", int'(inst1_srca_preg), 33);
		if (inst1_dest_preg !== preg_t'(0) || halt1)
			report_mismatch("zero reg write dest", int'(inst1_dest_preg), 0);
	endtask

	task automatic fill_free_list();
		int   tries;
		logic saw_last;
		tries = 0;
		saw_last = 1'b0;
		@(negedge clock);
		drive_idle();
		drive_inst1(areg_t'(4), areg_t'(5), areg_t'(5), 1'b1);   // leaves an odd count
		#2;
		while (!halt1 && tries < 40) begin
			@(negedge clock);
			issue_pair(1'b1);
			#2;
			tries++;
			if (count_ones(free_ref) == 1) begin
				saw_last = 1'b1;
				if (halt1 || !halt2)
					report_mismatch("halts with one tag left", int'({halt1, halt2}), 1);
				if (inst1_dest_preg !== preg_t'(`RENAME_PRF_SIZE - 1))
					report_mismatch("last tag", int'(inst1_dest_preg), 63);
			end
			if (halt1 && count_ones(free_ref) != 0)
				report_mismatch("halt1 with tags left", count_ones(free_ref), 0);
		end
		if (!halt1) begin
			errors++;
			timed_out = 1'b1;
			$display("ERROR: halt1 never rose within 40 cycles while filling the free list");
		end else if (!saw_last) begin
			errors++;
			$display("ERROR: the free list never reached a single free tag");
		end
	endtask

	task automatic retire_front();
		retire_valid = 1'b1;
		retire_areg = inflight_areg[0];
		retire_preg = inflight_preg[0];
	endtask

	task automatic check_release();
		areg_t first_areg;
		@(negedge clock);
		drive_idle();
		first_areg = inflight_areg[0];                         // committed tag still identity
		retire_front();
		@(negedge clock);
		drive_idle();
		drive_inst1(areg_t'(6), areg_t'(7), areg_t'(7), 1'b1);
		#2;
		if (inst1_dest_preg !== preg_t'(first_areg))
			report_mismatch("released tag offered", int'(inst1_dest_preg), int'(first_areg));
		if (free_count !== free_count_t'(0))
			report_mismatch("free_count at release", int'(free_count), 0);
		@(negedge clock);
		drive_idle();
		#2;
		if (free_count !== free_count_t'(1))
			report_mismatch("free_count after release", int'(free_count), 1);
		repeat (4) begin
			@(negedge clock);
			drive_idle();
			retire_front();
		end
	endtask

	task automatic check_restore();
		@(negedge clock);
		drive_idle();
		drive_inst1(areg_t'(8), areg_t'(9), areg_t'(10), 1'b1);
		mispredict = 1'b1;
		#2;
		if (!halt1 || !halt2 || inst1_dest_preg !== preg_t'(0))
			report_mismatch("halts during mispredict", int'({halt1, halt2}), 3);
		for (int i = 0; i < `RENAME_ARF_SIZE; i++) begin
			@(negedge clock);
			drive_idle();
			drive_inst1(areg_t'(i), areg_t'(i), areg_t'(0), 1'b0);
			#2;
			if (inst1_srca_preg !== comm_ref[i])
				report_mismatch("restored lookup", int'(inst1_srca_preg), int'(comm_ref[i]));
		end
		if (int'(free_count) != `RENAME_PRF_SIZE - count_distinct())
			report_mismatch("free_count after restore", int'(free_count),
				`RENAME_PRF_SIZE - count_distinct());
	endtask

	task automatic random_mix(input int total);
		for (int c = 0; c < total; c++) begin
			@(negedge clock);
			issue_pair(1'b0);
			mispredict = !mispredict && (($random(seed) & 63) == 0);   // single-cycle pulse
			retire_valid = 1'b0;
			if (inflight_areg.size() > 0 && (($random(seed) & 1) != 0))
				retire_front();
		end
	endtask

	initial begin
		seed = 32'hb4c9_60fc;
		errors = 0;
		cycles = 0;
		timed_out = 1'b0;
		clock = 1'b0;
		reset = 1'b1;
		drive_idle();
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		check_reset_lookups();
		check_pair_rename();
		fill_free_list();
		if (!timed_out) begin
			check_release();
			check_restore();
			random_mix(3000);
		end
		@(negedge clock);
		drive_idle();
		repeat (2) @(posedge clock);
		$display("cycles compared: %0d, errors: %0d", cycles, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
design/rename_pkg.sv
design/rename_map_table.sv
design/retire_map_table.sv
design/prf_free_list.sv
design/rename_stage.sv
sim/rename_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the rename stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module rename_stage_tb
build_status=$?
if [ "$build_status" -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

sim_output=$(./obj_dir/Vrename_stage_tb)
sim_status=$?
printf '%s\n' "$sim_output"
if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_output" | grep -q '^Simulation passed$'; then
	exit 0
fi

echo "pass message not found in simulation output"
exit 1
